//--- hw/residuPkg.sv
`default_nettype none

package residuPkg;

	//////////////////////////////////////////////////
	// Memory geometry
	//////////////////////////////////////////////////

	localparam int MEM_DEPTH = 2048;
	localparam int ADDR_W = $clog2(MEM_DEPTH);

	//////////////////////////////////////////////////
	// Word types
	//////////////////////////////////////////////////

	// Samples, coefficients and y
	typedef logic signed [15:0] word16T;

	// Accumulator and shifter values
	typedef logic signed [31:0] word32T;

	// Raw memory word, samples sign-extended
	typedef logic [31:0] memDataT;

	typedef logic [ADDR_W-1:0] addrT;

	// Frame length lg, up to 63
	typedef logic [5:0] lenT;

	//////////////////////////////////////////////////
	// Filter constants
	//////////////////////////////////////////////////

	// 10th order, 11 taps
	localparam int ORDER = 10;

	// Left shift ahead of rounding
	localparam int RES_SHIFT = 3;

	localparam word32T ROUND_CONST = 32'h00008000;

	// Saturation limits
	localparam word32T MAX32 = 32'h7fffffff;
	localparam word32T MIN32 = 32'h80000000;
	localparam word16T MAX16 = 16'h7fff;
	localparam word16T MIN16 = 16'h8000;

endpackage

`default_nettype wire

//--- hw/dspBus.sv
`timescale 1ns/1ns
`default_nettype none

interface dspBus;
	import residuPkg::*;

	// Multiply-accumulate
	word16T macA;
	word16T macB;
	word32T macAcc;
	logic macFirst;
	word32T macOut;

	// Shifter handshake and data
	word32T shVar;
	logic shReady;
	logic shDone;
	word32T shOut;

	// Rounding
	word32T rndIn;
	word16T rndOut;

	modport fsm (
		output macA, macB, macAcc, macFirst, shVar, shReady, rndIn,
		input macOut, rndOut, shDone, shOut
	);

	modport alu (
		input macA, macB, macAcc, macFirst, rndIn,
		output macOut, rndOut
	);

	modport shifter (
		input shVar, shReady,
		output shDone, shOut
	);

endinterface

`default_nettype wire

//--- hw/satAlu.sv
`timescale 1ns/1ns
`default_nettype none

module satAlu (
	dspBus.alu bus
);
	import residuPkg::*;

	// 32-bit add, clamps when both operands share a sign the sum lost
	function automatic word32T satAdd32(input word32T x, input word32T y);
		word32T s;
		s = x + y;
		if ((x[31] == y[31]) && (s[31] != x[31]))
		begin
			return x[31] ? MIN32 : MAX32;
		end
		return s;
	endfunction

	word32T product;
	word32T mult;
	word32T rndSum;

	//////////////////////////////////////////////////
	// L_mult and L_mac
	//////////////////////////////////////////////////

	always_comb
	begin
		product = word32T'(bus.macA) * word32T'(bus.macB);
		// Only -32768 * -32768 overflows after the doubling
		if ((bus.macA == MIN16) && (bus.macB == MIN16))
		begin
			mult = MAX32;
		end
		else
		begin
			mult = product <<< 1;
		end
	end

	// First tap ignores the running sum
	assign bus.macOut = bus.macFirst ? mult : satAdd32(bus.macAcc, mult);

	//////////////////////////////////////////////////
	// round
	//////////////////////////////////////////////////

	always_comb
	begin
		rndSum = bus.rndIn + ROUND_CONST;
		// Constant is positive, so only a positive input can wrap
		if (!bus.rndIn[31] && rndSum[31])
		begin
			bus.rndOut = MAX16;
		end
		else
		begin
			bus.rndOut = rndSum[31:16];
		end
	end

endmodule

`default_nettype wire

//--- hw/satShifter.sv
`timescale 1ns/1ns
`default_nettype none

module satShifter (
	input logic clk,
	input logic rstN,
	dspBus.shifter bus
);
	import residuPkg::*;

	localparam int CNT_W = $clog2(RES_SHIFT + 1);

	word32T shReg;
	logic [CNT_W-1:0] cnt;
	logic active;
	logic ovf;

	// Next doubling would change the sign bit
	assign ovf = shReg[31] != shReg[30];

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (bus.shReady)
		begin
			shReg <= bus.shVar;
		end
		else if (active)
		begin
			if (ovf)
			begin
				shReg <= shReg[31] ? MIN32 : MAX32;
			end
			else
			begin
				shReg <= shReg <<< 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Count and done pulse
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			active <= 1'b0;
			cnt <= '0;
			bus.shDone <= 1'b0;
		end
		else
		begin
			bus.shDone <= 1'b0;
			if (bus.shReady)
			begin
				active <= 1'b1;
				cnt <= CNT_W'(RES_SHIFT);
			end
			else if (active)
			begin
				cnt <= cnt - 1'b1;
				// Saturated value stays put, so stop early
				if (ovf || (cnt == CNT_W'(1)))
				begin
					active <= 1'b0;
					bus.shDone <= 1'b1;
				end
			end
		end
	end

	// Held until the next load
	assign bus.shOut = shReg;

endmodule

`default_nettype wire

//--- hw/scratchMem.sv
`timescale 1ns/1ns
`default_nettype none

module scratchMem (
	input logic clk,
	input residuPkg::addrT wrAddr,
	input residuPkg::memDataT wrData,
	input logic wrEn,
	input residuPkg::addrT rdAddr,
	output residuPkg::memDataT rdData
);
	import residuPkg::*;

	memDataT mem [MEM_DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

//--- hw/residuFsm.sv
`timescale 1ns/1ns
`default_nettype none

module residuFsm (
	input logic clk,
	input logic rstN,
	input logic start,
	input residuPkg::lenT lg,
	input residuPkg::addrT aBase,
	input residuPkg::addrT xBase,
	input residuPkg::addrT yBase,
	output logic busy,
	output logic done,
	output residuPkg::addrT aRdAddr,
	input residuPkg::memDataT aRdData,
	output residuPkg::addrT xRdAddr,
	input residuPkg::memDataT xRdData,
	output residuPkg::addrT yWrAddr,
	output residuPkg::memDataT yWrData,
	output logic yWrEn,
	dspBus.fsm bus
);
	import residuPkg::*;

	typedef enum logic [2:0] {
		idle,
		readFirst,
		accumulate,
		shift,
		write,
		finish
	} residuStateT;

	// Tap counter runs one past the last tap for the read latency
	localparam int TAP_W = $clog2(ORDER + 2);

	residuStateT state;
	lenT n;
	logic [TAP_W-1:0] j;
	logic firstTap;
	logic lastTap;
	logic lastSample;
	word32T acc;
	word16T yWord;

	// Data now on the read ports belongs to tap ORDER
	assign lastTap = j == TAP_W'(ORDER + 1);
	assign lastSample = n == (lg - lenT'(1));

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= idle;
			n <= '0;
			j <= '0;
			firstTap <= 1'b0;
			bus.shReady <= 1'b0;
		end
		else
		begin
			bus.shReady <= 1'b0;
			case (state)
				idle:
				begin
					if (start)
					begin
						n <= '0;
						j <= '0;
						state <= readFirst;
					end
				end
				readFirst:
				begin
					// Tap 0 address is on the ports now
					j <= j + 1'b1;
					firstTap <= 1'b1;
					state <= accumulate;
				end
				accumulate:
				begin
					firstTap <= 1'b0;
					j <= j + 1'b1;
					if (lastTap)
					begin
						bus.shReady <= 1'b1;
						state <= shift;
					end
				end
				shift:
				begin
					if (bus.shDone)
					begin
						state <= write;
					end
				end
				write:
				begin
					if (lastSample)
					begin
						state <= finish;
					end
					else
					begin
						n <= n + 1'b1;
						j <= '0;
						state <= readFirst;
					end
				end
				finish:
				begin
					state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Datapath registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == accumulate)
		begin
			acc <= bus.macOut;
		end
		if ((state == shift) && bus.shDone)
		begin
			yWord <= bus.rndOut;
		end
	end

	// Paired reads of a[j] and x[n-j]
	assign aRdAddr = aBase + addrT'(j);
	assign xRdAddr = xBase + addrT'(n) - addrT'(j);

	// Samples sit in the low half of each word
	assign bus.macA = word16T'(aRdData[15:0]);
	assign bus.macB = word16T'(xRdData[15:0]);
	assign bus.macAcc = acc;
	assign bus.macFirst = firstTap;
	assign bus.shVar = acc;
	assign bus.rndIn = bus.shOut;

	// y write, sign-extended
	assign yWrAddr = yBase + addrT'(n);
	assign yWrData = memDataT'({{16{yWord[15]}}, yWord});
	assign yWrEn = state == write;

	// done and the fall of busy share the finish cycle
	assign busy = (state != idle) && (state != finish);
	assign done = state == finish;

endmodule

`default_nettype wire

//--- hw/residuTop.sv
`timescale 1ns/1ns
`default_nettype none

module residuTop (
	input logic clk,
	input logic rstN,
	input logic start,
	input residuPkg::lenT lg,
	input residuPkg::addrT aBase,
	input residuPkg::addrT xBase,
	input residuPkg::addrT yBase,
	output logic busy,
	output logic done,
	input logic hostSel,
	input residuPkg::addrT memAWrAddr,
	input residuPkg::memDataT memAWrData,
	input logic memAWrEn,
	input residuPkg::addrT memARdAddr,
	output residuPkg::memDataT memARdData,
	input residuPkg::addrT memXWrAddr,
	input residuPkg::memDataT memXWrData,
	input logic memXWrEn
);
	import residuPkg::*;

	dspBus bus ();

	// FSM side of the memories
	addrT fsmARdAddr;
	addrT fsmXRdAddr;
	addrT fsmYWrAddr;
	memDataT fsmYWrData;
	logic fsmYWrEn;
	memDataT memXRdData;

	// Memory 1 port after the select
	addrT memAWrAddrSel;
	memDataT memAWrDataSel;
	logic memAWrEnSel;
	addrT memARdAddrSel;

	//////////////////////////////////////////////////
	// Memory 1 owner, 0 host and 1 FSM
	//////////////////////////////////////////////////

	always_comb
	begin
		if (hostSel)
		begin
			memAWrAddrSel = fsmYWrAddr;
			memAWrDataSel = fsmYWrData;
			memAWrEnSel = fsmYWrEn;
			memARdAddrSel = fsmARdAddr;
		end
		else
		begin
			memAWrAddrSel = memAWrAddr;
			memAWrDataSel = memAWrData;
			memAWrEnSel = memAWrEn;
			memARdAddrSel = memARdAddr;
		end
	end

	residuFsm u_fsm (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.lg(lg),
		.aBase(aBase),
		.xBase(xBase),
		.yBase(yBase),
		.busy(busy),
		.done(done),
		.aRdAddr(fsmARdAddr),
		.aRdData(memARdData),
		.xRdAddr(fsmXRdAddr),
		.xRdData(memXRdData),
		.yWrAddr(fsmYWrAddr),
		.yWrData(fsmYWrData),
		.yWrEn(fsmYWrEn),
		.bus(bus.fsm)
	);

	satAlu u_alu (
		.bus(bus.alu)
	);

	satShifter u_shifter (
		.clk(clk),
		.rstN(rstN),
		.bus(bus.shifter)
	);

	// Coefficients and y
	scratchMem u_memA (
		.clk(clk),
		.wrAddr(memAWrAddrSel),
		.wrData(memAWrDataSel),
		.wrEn(memAWrEnSel),
		.rdAddr(memARdAddrSel),
		.rdData(memARdData)
	);

	// Speech samples with history
	scratchMem u_memX (
		.clk(clk),
		.wrAddr(memXWrAddr),
		.wrData(memXWrData),
		.wrEn(memXWrEn),
		.rdAddr(fsmXRdAddr),
		.rdData(memXRdData)
	);

endmodule

`default_nettype wire

//--- include/g729Ref.svh
`ifndef G729_REF_SVH
`define G729_REF_SVH

// Saturating 32-bit add
function automatic int saturatingAdd(input int a, input int b);
	longint s;
	s = longint'(a) + longint'(b);
	if (s > 64'sd2147483647)
	begin
		return 32'h7fffffff;
	end
	if (s < -64'sd2147483648)
	begin
		return int'(32'h80000000);
	end
	return int'(s);
endfunction

function automatic int doubledProduct(input int a, input int b);
	if ((a == -32768) && (b == -32768))
	begin
		return 32'h7fffffff;
	end
	return a * b * 2;
endfunction

function automatic int macStep(input int acc, input int a, input int b);
	return saturatingAdd(acc, doubledProduct(a, b));
endfunction

// Left shift with clamp at the first overflow
function automatic int shiftLeftSat(input int v, input int n);
	int r;
	r = v;
	for (int i = 0; i < n; i++)
	begin
		if (r > 32'sh3fffffff)
		begin
			return 32'h7fffffff;
		end
		if (r < -1073741824)
		begin
			return int'(32'h80000000);
		end
		r = r * 2;
	end
	return r;
endfunction

// Sign-extended high half of the rounded word
function automatic int roundHigh(input int v);
	return saturatingAdd(v, 32'h00008000) >>> 16;
endfunction

// One Residu frame
// Sample n sits at x[xOff + n] with the history below xOff
function automatic void residuModel(input int a[], input int x[], input int xOff,
		input int lg, output int y[]);
	int acc;
	y = new[lg];
	for (int n = 0; n < lg; n++)
	begin
		acc = doubledProduct(a[0], x[xOff + n]);
		for (int j = 1; j <= 10; j++)
		begin
			acc = macStep(acc, a[j], x[xOff + n - j]);
		end
		y[n] = roundHigh(shiftLeftSat(acc, 3));
	end
endfunction

`endif

//--- dv/residuTb.sv
`timescale 1ns/1ns
`default_nettype none

module residuTb;
	import residuPkg::*;

	`include "g729Ref.svh"

	localparam int TIMEOUT_CYCLES = 4000;
	// Long enough for a whole second frame to show up
	localparam int WATCH_CYCLES = 400;
	localparam int A_BASE = 24;

	logic clk;
	logic rstN;
	logic start;
	lenT lg;
	addrT aBase;
	addrT xBase;
	addrT yBase;
	logic busy;
	logic done;
	logic hostSel;
	addrT memAWrAddr;
	memDataT memAWrData;
	logic memAWrEn;
	addrT memARdAddr;
	memDataT memARdData;
	addrT memXWrAddr;
	memDataT memXWrData;
	logic memXWrEn;

	// Coefficients and a copy of memory 2 for the model
	int coef[];
	int xShadow[];
	int testCount;
	int failedTests;
	int errorCount;

	residuTop u_dut (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.lg(lg),
		.aBase(aBase),
		.xBase(xBase),
		.yBase(yBase),
		.busy(busy),
		.done(done),
		.hostSel(hostSel),
		.memAWrAddr(memAWrAddr),
		.memAWrData(memAWrData),
		.memAWrEn(memAWrEn),
		.memARdAddr(memARdAddr),
		.memARdData(memARdData),
		.memXWrAddr(memXWrAddr),
		.memXWrData(memXWrData),
		.memXWrEn(memXWrEn)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Host access
	//////////////////////////////////////////////////

	task automatic writeWordA(input int addr, input memDataT data);
		@(negedge clk);
		hostSel = 1'b0;
		memAWrAddr = addrT'(addr);
		memAWrData = data;
		memAWrEn = 1'b1;
		@(negedge clk);
		memAWrEn = 1'b0;
	endtask

	task automatic writeCoefs();
		for (int j = 0; j <= ORDER; j++)
		begin
			writeWordA(A_BASE + j, memDataT'(coef[j]));
		end
	endtask

	task automatic writeSample(input int addr, input int val);
		@(negedge clk);
		memXWrAddr = addrT'(addr);
		memXWrData = memDataT'(val);
		memXWrEn = 1'b1;
		xShadow[addr] = val;
		@(negedge clk);
		memXWrEn = 1'b0;
	endtask

	// Read data is stable by the next falling edge
	task automatic readWordA(input int addr, output memDataT data);
		@(negedge clk);
		hostSel = 1'b0;
		memARdAddr = addrT'(addr);
		@(negedge clk);
		data = memARdData;
	endtask

	// Word that depends on every address bit
	function automatic memDataT fillPattern(input int addr);
		return memDataT'(32'hc3a50000 ^ (addr * 32'h00010001));
	endfunction

	//////////////////////////////////////////////////
	// Run and check
	//////////////////////////////////////////////////

	// restartAt above 0 pulses start again that many cycles in
	task automatic runFrame(input int len, input int xb, input int yb, input int restartAt,
			output int doneCount);
		int cycles;
		@(negedge clk);
		lg = lenT'(len);
		xBase = addrT'(xb);
		yBase = addrT'(yb);
		hostSel = 1'b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		doneCount = 0;
		cycles = 0;
		while ((doneCount == 0) && (cycles < TIMEOUT_CYCLES))
		begin
			@(negedge clk);
			cycles++;
			start = (cycles == restartAt);
			if (done)
			begin
				doneCount++;
			end
		end
		start = 1'b0;
		if (doneCount == 0)
		begin
			$display("Timed out after %0d cycles waiting for done", cycles);
		end
		else if (restartAt > 0)
		begin
			for (int i = 0; i < WATCH_CYCLES; i++)
			begin
				@(negedge clk);
				if (done)
				begin
					doneCount++;
				end
			end
		end
		@(negedge clk);
		hostSel = 1'b0;
	endtask

	task automatic checkResidual(input string name, input int yb, input int len, input int xb,
			inout int errs);
		int yExp[];
		memDataT d;
		residuModel(coef, xShadow, xb, len, yExp);
		for (int n = 0; n < len; n++)
		begin
			readWordA(yb + n, d);
			if (int'(d) != yExp[n])
			begin
				$display("error %s: y[%0d] expected %0d, actual %0d", name, n, yExp[n], int'(d));
				errs++;
			end
		end
	endtask

	task automatic checkDoneCount(input string name, input int doneCount, inout int errs);
		if (doneCount != 1)
		begin
			$display("error %s: done count expected 1, actual %0d", name, doneCount);
			errs++;
		end
	endtask

	task automatic finishTest(input string name, input int errs);
		testCount++;
		if (errs > 0)
		begin
			failedTests++;
		end
		errorCount += errs;
		$display("%s: %s, %0d errors", name, (errs == 0) ? "passed" : "FAILED", errs);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic randomFrameTest();
		string name;
		int errs;
		int doneCount;
		name = "randomFrame";
		errs = 0;
		for (int j = 0; j <= ORDER; j++)
		begin
			coef[j] = int'($urandom_range(8192)) - 4096;
		end
		writeCoefs();
		// 10 history samples then 40 frame samples
		for (int i = 0; i < 50; i++)
		begin
			writeSample(i, int'($urandom_range(8192)) - 4096);
		end
		runFrame(40, 10, 100, 0, doneCount);
		checkDoneCount(name, doneCount, errs);
		if (doneCount == 1)
		begin
			checkResidual(name, 100, 40, 10, errs);
		end
		finishTest(name, errs);
	endtask

	task automatic saturationTest();
		string name;
		int errs;
		int doneCount;
		name = "saturation";
		errs = 0;
		for (int i = 400; i < 414; i++)
		begin
			writeSample(i, 32767);
		end
		// Positive clamp first, then negative
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int j = 0; j <= ORDER; j++)
			begin
				coef[j] = (pass == 0) ? 32767 : -32767;
			end
			writeCoefs();
			runFrame(4, 410, 100, 0, doneCount);
			checkDoneCount(name, doneCount, errs);
			if (doneCount == 1)
			begin
				checkResidual(name, 100, 4, 410, errs);
			end
		end
		finishTest(name, errs);
	endtask

	task automatic multCornerTest();
		string name;
		int errs;
		int doneCount;
		name = "multCorner";
		errs = 0;
		for (int j = 0; j <= ORDER; j++)
		begin
			coef[j] = (j == 0) ? -32768 : 0;
		end
		writeCoefs();
		for (int i = 500; i < 514; i++)
		begin
			writeSample(i, -32768);
		end
		runFrame(4, 510, 100, 0, doneCount);
		checkDoneCount(name, doneCount, errs);
		if (doneCount == 1)
		begin
			checkResidual(name, 100, 4, 510, errs);
		end
		finishTest(name, errs);
	endtask

	task automatic consecutiveFramesTest();
		string name;
		int errs;
		int doneCount;
		memDataT d;
		name = "consecutiveFrames";
		errs = 0;
		for (int j = 0; j <= ORDER; j++)
		begin
			coef[j] = int'($urandom_range(8192)) - 4096;
		end
		writeCoefs();
		for (int i = 300; i < 350; i++)
		begin
			writeSample(i, int'($urandom_range(8192)) - 4096);
		end
		for (int addr = 200; addr < 216; addr++)
		begin
			writeWordA(addr, fillPattern(addr));
		end
		runFrame(40, 310, 100, 0, doneCount);
		checkDoneCount(name, doneCount, errs);
		checkResidual(name, 100, 40, 310, errs);
		// Frame 2 history is the tail of frame 1
		for (int i = 350; i < 358; i++)
		begin
			writeSample(i, int'($urandom_range(8192)) - 4096);
		end
		runFrame(8, 350, 200, 0, doneCount);
		checkDoneCount(name, doneCount, errs);
		checkResidual(name, 200, 8, 350, errs);
		for (int addr = 208; addr < 216; addr++)
		begin
			readWordA(addr, d);
			if (d != fillPattern(addr))
			begin
				$display("error %s: word %0d expected %h, actual %h", name, addr,
					fillPattern(addr), d);
				errs++;
			end
		end
		finishTest(name, errs);
	endtask

	task automatic controlTest();
		string name;
		int errs;
		int doneCount;
		name = "control";
		errs = 0;
		// Frame that the reset cuts short
		@(negedge clk);
		lg = lenT'(4);
		xBase = addrT'(510);
		yBase = addrT'(150);
		hostSel = 1'b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (busy !== 1'b1)
		begin
			$display("error %s: busy expected 1, actual %b", name, busy);
			errs++;
		end
		repeat (5) @(negedge clk);
		rstN = 1'b0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		if (busy || done)
		begin
			$display("%s: busy or done high after reset", name);
			errs++;
		end
		hostSel = 1'b0;
		// Second start lands while busy
		runFrame(4, 510, 150, 5, doneCount);
		checkDoneCount(name, doneCount, errs);
		finishTest(name, errs);
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		lg = '0;
		aBase = addrT'(A_BASE);
		xBase = '0;
		yBase = '0;
		hostSel = 1'b0;
		memAWrAddr = '0;
		memAWrData = '0;
		memAWrEn = 1'b0;
		memARdAddr = '0;
		memXWrAddr = '0;
		memXWrData = '0;
		memXWrEn = 1'b0;
		void'($urandom(32'h0ae09a53));
		coef = new[ORDER + 1];
		xShadow = new[MEM_DEPTH];
		testCount = 0;
		failedTests = 0;
		errorCount = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		randomFrameTest();
		saturationTest();
		multCornerTest();
		consecutiveFramesTest();
		controlTest();

		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hw/residuPkg.sv
hw/dspBus.sv
hw/satAlu.sv
hw/satShifter.sv
hw/scratchMem.sv
hw/residuFsm.sv
hw/residuTop.sv
dv/residuTb.sv
